// ==== common/muladd_cfg_pkg.sv ====
package muladd_cfg_pkg;

   localparam int ITER_W   = 10;
   localparam int PERIOD_W = 10;
   localparam int DELAY_W  = 16;
   localparam int ADDR_W   = 3;

   typedef logic [ITER_W-1:0]   iter_t;
   typedef logic [PERIOD_W-1:0] period_t;
   typedef logic [DELAY_W-1:0]  delay_t;
   typedef logic [ADDR_W-1:0]   cfg_addr_t;

   // msub keeps the first product of a period and subtracts the rest.
   typedef enum logic [0:0] {
      OP_MACC = 1'b0,
      OP_MSUB = 1'b1
   } opcode_e;

   // register map of the configuration block.
   localparam cfg_addr_t CFG_OPCODE = 3'd0;
   localparam cfg_addr_t CFG_ITER   = 3'd1;
   localparam cfg_addr_t CFG_PERIOD = 3'd2;
   localparam cfg_addr_t CFG_SHIFT  = 3'd3;
   localparam cfg_addr_t CFG_DELAY  = 3'd4;

   typedef struct packed {
      opcode_e             opcode;
      iter_t               iterations;
      period_t             period;
      muladd_pkg::shift_t  shift;
      delay_t              delay;
   } muladd_cfg_t;

endpackage

// ==== common/muladd_pkg.sv ====
package muladd_pkg;

   // operand and output word width.
   localparam int DATA_W = 32;

   // the product keeps every bit, so the accumulator wraps at this width.
   localparam int ACC_W = 2 * DATA_W;

   // 6 bits reach every shift from 0 to 63.
   localparam int SHIFT_W = 6;

   // one signed operand or output word.
   typedef logic signed [DATA_W-1:0] data_t;

   // a full-width signed product or accumulator value.
   typedef logic signed [ACC_W-1:0] prod_t;

   // arithmetic right shift applied to the accumulator on output.
   typedef logic [SHIFT_W-1:0] shift_t;

endpackage

// ==== files.f ====
+incdir+tests
common/muladd_pkg.sv
common/muladd_cfg_pkg.sv
muladd/muladd_config.sv
muladd/muladd_sequencer.sv
muladd/muladd_datapath.sv
rtl/muladd_top.sv
tests/muladd_tb.sv

// ==== muladd/muladd_config.sv ====
`timescale 1ns/1ps

module muladd_config (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         cfg_we,
   input  muladd_cfg_pkg::cfg_addr_t    cfg_addr,
   input  logic [31:0]                  cfg_wdata,
   output muladd_cfg_pkg::muladd_cfg_t  cfg
);

   import muladd_cfg_pkg::*;
   import muladd_pkg::*;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cfg <= '0;
      end else if (cfg_we) begin
         case (cfg_addr)
            CFG_OPCODE: begin
               cfg.opcode <= opcode_e'(cfg_wdata[0]);
            end
            CFG_ITER: begin
               cfg.iterations <= cfg_wdata[ITER_W-1:0];
            end
            CFG_PERIOD: begin
               cfg.period <= cfg_wdata[PERIOD_W-1:0];
            end
            CFG_SHIFT: begin
               cfg.shift <= cfg_wdata[SHIFT_W-1:0];
            end
            CFG_DELAY: begin
               cfg.delay <= cfg_wdata[DELAY_W-1:0];
            end
            default: begin
               cfg <= cfg; // writes to unmapped addresses are ignored.
            end
         endcase
      end
   end

   // only the five mapped registers may be written.
   a_addr_mapped: assert property (
      @(posedge clk) disable iff (rst)
      cfg_we |-> cfg_addr <= CFG_DELAY
   ) else $error("configuration write to unmapped address %0d", cfg_addr);

   // a zero period with pending iterations would never close a period.
   a_period_nonzero: assert property (
      @(posedge clk) disable iff (rst)
      (cfg_we && cfg_addr == CFG_PERIOD && cfg.iterations != '0)
         |-> cfg_wdata[PERIOD_W-1:0] != '0
   ) else $error("period of zero written while iterations is %0d", cfg.iterations);

endmodule

// ==== muladd/muladd_datapath.sv ====
`timescale 1ns/1ps

module muladd_datapath (
   input  logic                         clk,
   input  logic                         rst,
   input  muladd_pkg::data_t            in0,
   input  muladd_pkg::data_t            in1,
   input  logic                         period_start,
   input  muladd_cfg_pkg::muladd_cfg_t  cfg,
   output muladd_pkg::data_t            out0
);

   import muladd_pkg::*;
   import muladd_cfg_pkg::*;

   data_t in0_q;
   data_t in1_q;
   prod_t prod_q;
   prod_t acc;
   prod_t acc_shifted;
   logic  start_d1;
   logic  start_d2;

   // operand and product stages carry data only.
   always_ff @(posedge clk) begin
      in0_q  <= in0;
      in1_q  <= in1;
      prod_q <= prod_t'(in0_q) * prod_t'(in1_q); // full signed product.
   end

   // two stages so the mark lines up with prod_q.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         start_d1 <= 1'b0;
         start_d2 <= 1'b0;
      end else begin
         start_d1 <= period_start;
         start_d2 <= start_d1;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         acc <= '0;
      end else if (start_d2) begin
         acc <= prod_q; // each period begins with a fresh sum.
      end else if (cfg.opcode == OP_MACC) begin
         acc <= acc + prod_q;
      end else begin
         acc <= acc - prod_q;
      end
   end

   // acc is signed, so this shift keeps the sign.
   assign acc_shifted = acc >>> cfg.shift;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         out0 <= '0;
      end else begin
         out0 <= acc_shifted[DATA_W-1:0];
      end
   end

   // the first product of a period must come from driven operands.
   a_start_known: assert property (
      @(posedge clk) disable iff (rst)
      start_d2 |-> !$isunknown(prod_q)
   ) else $error("unknown product at a period start");

endmodule

// ==== muladd/muladd_sequencer.sv ====
`timescale 1ns/1ps

module muladd_sequencer (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         run,
   input  muladd_cfg_pkg::muladd_cfg_t  cfg,
   output logic                         period_start,
   output logic                         done
);

   import muladd_cfg_pkg::*;

   typedef enum logic [1:0] {
      IDLE,
      WAIT,
      COUNT
   } state_e;

   state_e  state;
   delay_t  delay_cnt;
   period_t period_cnt;
   iter_t   iter_cnt;
   logic    period_last;
   logic    iter_last;

   // compared one bit wider so a count at its maximum cannot wrap.
   assign period_last = ({1'b0, period_cnt} + 1'b1) >= {1'b0, cfg.period};
   assign iter_last   = ({1'b0, iter_cnt} + 1'b1) >= {1'b0, cfg.iterations};

   // marks the cycle in which the first pair of a period sits on the inputs.
   assign period_start = (state == COUNT) && (period_cnt == '0) && (cfg.iterations != '0);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state      <= IDLE;
         delay_cnt  <= '0;
         period_cnt <= '0;
         iter_cnt   <= '0;
         done       <= 1'b0;
      end else if (run) begin
         // a run during a count starts over from element 0.
         state      <= (cfg.delay == '0) ? COUNT : WAIT;
         delay_cnt  <= cfg.delay - 1'b1;
         period_cnt <= '0;
         iter_cnt   <= '0;
         done       <= 1'b0;
      end else begin
         case (state)
            WAIT: begin
               if (delay_cnt == '0) begin
                  state <= COUNT;
               end else begin
                  delay_cnt <= delay_cnt - 1'b1;
               end
            end
            COUNT: begin
               if (cfg.iterations == '0) begin
                  state <= IDLE; // no element is taken in this case.
                  done  <= 1'b1;
               end else if (period_last) begin
                  period_cnt <= '0;
                  if (iter_last) begin
                     state <= IDLE;
                     done  <= 1'b1;
                  end else begin
                     iter_cnt <= iter_cnt + 1'b1;
                  end
               end else begin
                  period_cnt <= period_cnt + 1'b1;
               end
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

   // each mark moves the period counter on, so back to back marks need a period of one.
   a_start_advances: assert property (
      @(posedge clk) disable iff (rst)
      period_start && !run && cfg.period > 1 |=> !period_start
   ) else $error("period start held for two cycles with a period above one");

   // done is only set on the way out of COUNT and cleared by run.
   a_done_not_counting: assert property (
      @(posedge clk) disable iff (rst)
      !(done && state == COUNT)
   ) else $error("done is high while elements are still being taken");

endmodule

// ==== rtl/muladd_top.sv ====
`timescale 1ns/1ps

module muladd_top (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       cfg_we,
   input  muladd_cfg_pkg::cfg_addr_t  cfg_addr,
   input  logic [31:0]                cfg_wdata,
   input  logic                       run,
   input  muladd_pkg::data_t          in0,
   input  muladd_pkg::data_t          in1,
   output muladd_pkg::data_t          out0,
   output logic                       done
);

   import muladd_cfg_pkg::*;

   muladd_cfg_t cfg;
   logic        period_start;

   muladd_config config0 (
      .clk       (clk),
      .rst       (rst),
      .cfg_we    (cfg_we),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .cfg       (cfg)
   );

   // the sequencer sees the same record the datapath uses.
   muladd_sequencer seq0 (
      .clk          (clk),
      .rst          (rst),
      .run          (run),
      .cfg          (cfg),
      .period_start (period_start),
      .done         (done)
   );

   muladd_datapath dp0 (
      .clk          (clk),
      .rst          (rst),
      .in0          (in0),
      .in1          (in1),
      .period_start (period_start),
      .cfg          (cfg),
      .out0         (out0)
   );

endmodule

// ==== tests/muladd_model.svh ====
`ifndef MULADD_MODEL_SVH
`define MULADD_MODEL_SVH

logic    m_active = 1'b0;
int      m_t;
int      m_delay;
int      m_period;
int      m_len;
int      m_rise;
opcode_e m_opcode;
shift_t  m_shift;
prod_t   m_acc;
logic    done_exp = 1'b0; // done comes out of reset low.
int      checks = 0;

// out0 words owed by the DUT and the tick at which each one is due.
int      exp_cycle[$];
data_t   exp_out[$];

task automatic record_config(input opcode_e op, input int iter, input int period,
                             input shift_t sh, input int delay);
   m_active = 1'b0; // the new run is only tracked from its pulse on.
   m_opcode = op;
   m_shift  = sh;
   m_delay  = delay;
   m_period = period;
   m_len    = iter * period;
endtask

task automatic start_model();
   m_active = 1'b1;
   m_t      = 0; // the tick that drives run.
   m_rise   = (m_len == 0) ? m_delay + 2 : m_delay + 1 + m_len;
endtask

task automatic advance_model();
   if (m_active) begin
      m_t++;
      if (m_t == 1) begin
         done_exp = 1'b0;
      end
      if (m_t == m_rise) begin
         done_exp = 1'b1; // the tick after the last pair is taken.
      end
   end
endtask

task automatic take_pair(input data_t a, input data_t b);
   int    e;
   prod_t pa;
   prod_t pb;
   prod_t p;
   prod_t sh;
   if (m_active) begin
      e = m_t - m_delay - 1;
      if (e >= 0 && e < m_len) begin
         pa = a; // sign extended to the full width.
         pb = b;
         p  = pa * pb;
         if (e % m_period == 0) begin
            m_acc = p;
         end else if (m_opcode == OP_MACC) begin
            m_acc = m_acc + p;
         end else begin
            m_acc = m_acc - p;
         end
         if (e % m_period == m_period - 1) begin
            sh = m_acc >>> m_shift;
            exp_cycle.push_back(cycle_no + 4); // visible four falling edges later.
            exp_out.push_back(sh[DATA_W-1:0]);
         end
      end
   end
endtask

task automatic check_out(input data_t got, input data_t want);
   checks++;
   if (got !== want) begin
      fail_stop($sformatf("** Error: out0 = %h, expected %h at cycle %0d",
                          got, want, cycle_no));
   end
endtask

task automatic check_done(input logic got, input logic want);
   checks++;
   if (got !== want) begin
      fail_stop($sformatf("** Error: done = %h, expected %h at cycle %0d",
                          got, want, cycle_no));
   end
endtask

task automatic due_results();
   while (exp_cycle.size() != 0 && exp_cycle[0] == cycle_no) begin
      check_out(out0, exp_out[0]);
      void'(exp_cycle.pop_front());
      void'(exp_out.pop_front());
   end
endtask

`endif

// ==== tests/muladd_tb.sv ====
`timescale 1ns/1ps

module muladd_tb;

   import muladd_pkg::*;
   import muladd_cfg_pkg::*;

   localparam int RESET_CYCLES = 8;
   localparam int MAX_DELAY    = 15;
   localparam int MAX_PERIOD   = 8;
   localparam int MAX_ITER     = 7;
   localparam int RUN_CYCLES   = 6 + MAX_DELAY + 2 + MAX_PERIOD * MAX_ITER + 8;
   localparam int RUN_COUNT    = 13;
   localparam int BUDGET_NS    = (RESET_CYCLES + RUN_COUNT * RUN_CYCLES + 50) * 10;

   logic        clk = 1'b0;
   logic        rst;
   logic        cfg_we;
   cfg_addr_t   cfg_addr;
   logic [31:0] cfg_wdata;
   logic        run;
   data_t       in0;
   data_t       in1;
   data_t       out0;
   logic        done;
   logic [31:0] lfsr_state = 32'h39d3;
   int          cycle_no = 0;

   `include "muladd_model.svh"

   muladd_top dut0 (
      .clk       (clk),
      .rst       (rst),
      .cfg_we    (cfg_we),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .run       (run),
      .in0       (in0),
      .in1       (in1),
      .out0      (out0),
      .done      (done)
   );

   always #5 clk = ~clk;

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      int          i;
      r = '0;
      for (i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state); // one step per bit.
         r = {r[30:0], lfsr_state[0]};
      end
      return r;
   endfunction

   function automatic shift_t nonzero_shift();
      shift_t s;
      s = shift_t'(rand_bits(SHIFT_W));
      return (s == '0) ? shift_t'(1) : s;
   endfunction

   task automatic fail_stop(input string why);
      $display("%s", why);
      $display("tests failed");
      $fatal(1, "stopped at cycle %0d", cycle_no);
   endtask

   // checks what the DUT shows at this falling edge, then drives new operands.
   task automatic tick();
      @(negedge clk);
      cycle_no++;
      run    = 1'b0;
      cfg_we = 1'b0;
      advance_model();
      check_done(done, done_exp);
      due_results();
      in0 = rand_bits(DATA_W);
      in1 = rand_bits(DATA_W);
      take_pair(in0, in1);
   endtask

   task automatic write_cfg(input cfg_addr_t addr, input logic [31:0] data);
      tick();
      cfg_we    = 1'b1;
      cfg_addr  = addr;
      cfg_wdata = data;
   endtask

   task automatic configure(input opcode_e op, input int iter, input int period,
                            input shift_t sh, input int delay);
      write_cfg(CFG_OPCODE, 32'(op));
      write_cfg(CFG_PERIOD, period);
      write_cfg(CFG_ITER, iter);
      write_cfg(CFG_SHIFT, 32'(sh));
      write_cfg(CFG_DELAY, delay);
      record_config(op, iter, period, sh, delay);
   endtask

   task automatic pulse_run();
      tick();
      run = 1'b1;
      start_model();
   endtask

   task automatic wait_done();
      int n;
      n = 0;
      tick();
      while (done !== 1'b1 || exp_cycle.size() != 0) begin
         if (n > RUN_CYCLES) begin
            fail_stop("done never rose, or results were still owed long after run");
         end else begin
            tick();
            n++;
         end
      end
   endtask

   task automatic draw_config(output int delay, output int period, output int iter);
      delay  = rand_bits(4);
      period = rand_bits(3) + 1;
      iter   = rand_bits(3);
      if (iter == 0) begin
         iter = 1;
      end
   endtask

   task automatic random_run(input opcode_e op, input shift_t sh, input logic zero_iter);
      int delay;
      int period;
      int iter;
      draw_config(delay, period, iter);
      configure(op, zero_iter ? 0 : iter, period, sh, delay);
      pulse_run();
      wait_done();
   endtask

   // a second run lands while element k of the first one is on the inputs.
   task automatic restart_run();
      int delay;
      int period;
      int iter;
      int k;
      draw_config(delay, period, iter);
      configure(OP_MACC, iter, period, shift_t'(0), delay);
      pulse_run();
      k = rand_bits(4) % (iter * period);
      repeat (delay + k) tick();
      pulse_run();
      wait_done();
   endtask

   initial begin
      #(BUDGET_NS);
      fail_stop("watchdog expired before the tests finished");
   end

   initial begin
      rst       = 1'b1;
      cfg_we    = 1'b0;
      cfg_addr  = '0;
      cfg_wdata = '0;
      run       = 1'b0;
      in0       = '0;
      in1       = '0;
      repeat (RESET_CYCLES) @(negedge clk);
      rst = 1'b0;
      repeat (3) random_run(OP_MACC, shift_t'(0), 1'b0);
      repeat (3) random_run(OP_MSUB, shift_t'(0), 1'b0);
      repeat (3) random_run(opcode_e'(rand_bits(1)), nonzero_shift(), 1'b0);
      random_run(OP_MACC, shift_t'(0), 1'b1);
      restart_run();
      if (checks > 0) begin
         $display("all tests passed");
         $finish;
      end else begin
         fail_stop("no result was ever checked");
      end
   end

endmodule
